//--- vlog.f
+incdir+bench
hw/alu_pkg.sv
hw/instr_decode.sv
hw/alu_execute.sv
hw/result_writeback.sv
hw/alu_unit_top.sv
bench/alu_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the alu unit testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module alu_unit_tb --Mdir "$OBJ" -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/Valu_unit_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Regression passed" "$LOG"; then
    echo "no result found in $LOG"
    exit 1
fi
exit 0

//--- bench/alu_unit_vectors.svh
task load_vectors;
    // op, rd, rs1, rs2, imm, expected result, zero, overflow, illegal
    // r0 stays zero so the readbacks can or against it
    add_row(alu_pkg::OP_LDI, 0, 0, 0, 32'h00000000, 32'h00000000, 1, 0, 0);
    add_row(alu_pkg::OP_LDI, 1, 0, 0, 32'h7fffffff, 32'h7fffffff, 0, 0, 0);
    add_row(alu_pkg::OP_LDI, 2, 0, 0, 32'h00000001, 32'h00000001, 0, 0, 0);
    add_row(alu_pkg::OP_LDI, 3, 0, 0, 32'h80000000, 32'h80000000, 0, 0, 0);
    add_row(alu_pkg::OP_LDI, 4, 0, 0, 32'hffffffff, 32'hffffffff, 0, 0, 0);
    add_row(alu_pkg::OP_LDI, 5, 0, 0, 32'h0000000a, 32'h0000000a, 0, 0, 0);
    add_row(alu_pkg::OP_LDI, 6, 0, 0, 32'hfffffff6, 32'hfffffff6, 0, 0, 0);
    add_row(alu_pkg::OP_LDI, 7, 0, 0, 32'h12345678, 32'h12345678, 0, 0, 0);
    add_row(alu_pkg::OP_OR,  1, 1, 0, 32'h00000000, 32'h7fffffff, 0, 0, 0);
    add_row(alu_pkg::OP_OR,  2, 2, 0, 32'h00000000, 32'h00000001, 0, 0, 0);
    add_row(alu_pkg::OP_OR,  3, 3, 0, 32'h00000000, 32'h80000000, 0, 0, 0);
    add_row(alu_pkg::OP_OR,  4, 4, 0, 32'h00000000, 32'hffffffff, 0, 0, 0);
    add_row(alu_pkg::OP_OR,  5, 5, 0, 32'h00000000, 32'h0000000a, 0, 0, 0);
    add_row(alu_pkg::OP_OR,  6, 6, 0, 32'h00000000, 32'hfffffff6, 0, 0, 0);
    add_row(alu_pkg::OP_OR,  7, 7, 0, 32'h00000000, 32'h12345678, 0, 0, 0);
    // arithmetic and logic, all into r7
    add_row(alu_pkg::OP_ADD, 7, 1, 2, 32'h00000000, 32'h80000000, 0, 1, 0);
    add_row(alu_pkg::OP_SUB, 7, 3, 2, 32'h00000000, 32'h7fffffff, 0, 1, 0);
    add_row(alu_pkg::OP_ADD, 7, 5, 6, 32'h00000000, 32'h00000000, 1, 0, 0);
    add_row(alu_pkg::OP_SUB, 7, 5, 2, 32'h00000000, 32'h00000009, 0, 0, 0);
    add_row(alu_pkg::OP_ADD, 7, 4, 4, 32'h00000000, 32'hfffffffe, 0, 0, 0);
    add_row(alu_pkg::OP_AND, 7, 1, 4, 32'h00000000, 32'h7fffffff, 0, 0, 0);
    add_row(alu_pkg::OP_XOR, 7, 1, 3, 32'h00000000, 32'hffffffff, 0, 0, 0);
    add_row(alu_pkg::OP_NOT, 7, 3, 0, 32'h00000000, 32'h7fffffff, 0, 0, 0);
    add_row(alu_pkg::OP_XOR, 7, 4, 4, 32'h00000000, 32'h00000000, 1, 0, 0);
    add_row(alu_pkg::OP_SUB, 7, 6, 1, 32'h00000000, 32'h7ffffff7, 0, 1, 0);
    // signed compares, r5 = 10, r6 = -10
    add_row(alu_pkg::OP_EQ,  7, 5, 5, 32'h00000000, 32'h00000001, 0, 0, 0);
    add_row(alu_pkg::OP_EQ,  7, 5, 6, 32'h00000000, 32'h00000000, 1, 0, 0);
    add_row(alu_pkg::OP_LT,  7, 6, 5, 32'h00000000, 32'h00000001, 0, 0, 0);
    add_row(alu_pkg::OP_LT,  7, 5, 6, 32'h00000000, 32'h00000000, 1, 0, 0);
    add_row(alu_pkg::OP_GT,  7, 5, 6, 32'h00000000, 32'h00000001, 0, 0, 0);
    add_row(alu_pkg::OP_GT,  7, 3, 1, 32'h00000000, 32'h00000000, 1, 0, 0);
    add_row(alu_pkg::OP_LT,  7, 3, 4, 32'h00000000, 32'h00000001, 0, 0, 0);
    // dependent chain, bypass and register file reads mixed
    add_row(alu_pkg::OP_LDI, 0, 0, 0, 32'h00000005, 32'h00000005, 0, 0, 0);
    add_row(alu_pkg::OP_ADD, 0, 0, 0, 32'h00000000, 32'h0000000a, 0, 0, 0);
    add_row(alu_pkg::OP_ADD, 1, 0, 2, 32'h00000000, 32'h0000000b, 0, 0, 0);
    add_row(alu_pkg::OP_SUB, 3, 1, 0, 32'h00000000, 32'h00000001, 0, 0, 0);
    add_row(alu_pkg::OP_XOR, 3, 3, 5, 32'h00000000, 32'h0000000b, 0, 0, 0);
    add_row(alu_pkg::OP_EQ,  4, 3, 1, 32'h00000000, 32'h00000001, 0, 0, 0);
    add_row(alu_pkg::OP_AND, 4, 4, 2, 32'h00000000, 32'h00000001, 0, 0, 0);
    // illegal codes must leave r5 and r6 alone
    add_row(4'd10,           5, 0, 0, 32'hdeadbeef, 32'h00000000, 0, 0, 1);
    add_row(alu_pkg::OP_OR,  6, 5, 5, 32'h00000000, 32'h0000000a, 0, 0, 0);
    add_row(4'd15,           6, 0, 0, 32'h00000000, 32'h00000000, 0, 0, 1);
    add_row(alu_pkg::OP_ADD, 7, 6, 5, 32'h00000000, 32'h00000014, 0, 0, 0);
    add_row(alu_pkg::OP_OR,  6, 6, 6, 32'h00000000, 32'h0000000a, 0, 0, 0);
endtask

//--- bench/alu_unit_tb.sv
`timescale 1ns/1ns

module alu_unit_tb;

    localparam int WIDTH    = alu_pkg::DEFAULT_WIDTH;
    localparam int REGS     = alu_pkg::DEFAULT_REGS;
    localparam int IDX_W    = $clog2(REGS);
    localparam int LATENCY  = 3;
    localparam int RST_CYC  = 5;
    localparam int MAX_ROWS = 64;

    logic                        clk;
    logic                        rst;
    logic                        in_valid;
    logic [alu_pkg::OP_BITS-1:0] in_op;
    logic [IDX_W-1:0]            in_rd;
    logic [IDX_W-1:0]            in_rs1;
    logic [IDX_W-1:0]            in_rs2;
    logic [WIDTH-1:0]            in_imm;
    logic                        done;
    logic [IDX_W-1:0]            done_rd;
    logic [WIDTH-1:0]            done_result;
    logic                        done_zero;
    logic                        done_overflow;
    logic                        illegal;

    // stimulus and expected values, one entry per row
    logic [alu_pkg::OP_BITS-1:0] t_op   [MAX_ROWS];
    logic [IDX_W-1:0]            t_rd   [MAX_ROWS];
    logic [IDX_W-1:0]            t_rs1  [MAX_ROWS];
    logic [IDX_W-1:0]            t_rs2  [MAX_ROWS];
    logic [WIDTH-1:0]            t_imm  [MAX_ROWS];
    logic [WIDTH-1:0]            t_res  [MAX_ROWS];
    bit                          t_zero [MAX_ROWS];
    bit                          t_ovf  [MAX_ROWS];
    bit                          t_ill  [MAX_ROWS];
    int                          issue_cyc [MAX_ROWS];

    int done_q[$];
    int ill_q[$];
    int num_rows;
    int cyc;
    int cur_row;
    int errors;
    int row_errs;
    int rows_finished;
    int timeout_limit;

    alu_unit_top #(
        .WIDTH (WIDTH),
        .REGS  (REGS)
    ) dut0 (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_op         (in_op),
        .in_rd         (in_rd),
        .in_rs1        (in_rs1),
        .in_rs2        (in_rs2),
        .in_imm        (in_imm),
        .done          (done),
        .done_rd       (done_rd),
        .done_result   (done_result),
        .done_zero     (done_zero),
        .done_overflow (done_overflow),
        .illegal       (illegal)
    );

    task add_row(input logic [alu_pkg::OP_BITS-1:0] op, input int rd, input int rs1,
                 input int rs2, input logic [WIDTH-1:0] imm, input logic [WIDTH-1:0] res,
                 input int zero, input int ovf, input int ill);
        t_op[num_rows]   = op;
        t_rd[num_rows]   = IDX_W'(rd);
        t_rs1[num_rows]  = IDX_W'(rs1);
        t_rs2[num_rows]  = IDX_W'(rs2);
        t_imm[num_rows]  = imm;
        t_res[num_rows]  = res;
        t_zero[num_rows] = (zero != 0);
        t_ovf[num_rows]  = (ovf != 0);
        t_ill[num_rows]  = (ill != 0);
        num_rows++;
    endtask

    `include "alu_unit_vectors.svh"

    task check_value(input int row, input string name, input logic [31:0] got,
                     input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL row %0d %s: got %h expected %h", row, name, got, exp);
            errors++;
            row_errs++;
        end
    endtask

    task report_row(input int idx, input string what);
        if (row_errs == 0) begin
            $display("row %0d op %0d rd %0d: %s ok", idx, t_op[idx], t_rd[idx], what);
        end else begin
            $display("row %0d op %0d rd %0d: %s mismatch", idx, t_op[idx], t_rd[idx], what);
        end
        rows_finished++;
    endtask

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    always @(posedge clk) begin
        if (cyc > timeout_limit) begin
            $display("timeout after %0d cycles: %0d completions and %0d illegal pulses missing",
                     cyc, done_q.size(), ill_q.size());
            $display("Regression failed");
            $finish;
        end
    end

    // outputs are registered, so look at them half a cycle later
    always @(negedge clk) begin
        int idx;
        if (!rst) begin
            if (done) begin
                if (done_q.size() == 0) begin
                    $display("completion for rd %0d arrived with nothing outstanding", done_rd);
                    errors++;
                end else begin
                    idx = done_q.pop_front();
                    row_errs = 0;
                    check_value(idx, "done_rd", 32'(done_rd), 32'(t_rd[idx]));
                    check_value(idx, "done_result", done_result, t_res[idx]);
                    check_value(idx, "done_zero", 32'(done_zero), 32'(t_zero[idx]));
                    check_value(idx, "done_overflow", 32'(done_overflow), 32'(t_ovf[idx]));
                    check_value(idx, "latency", cyc - issue_cyc[idx], LATENCY);
                    report_row(idx, "done");
                end
            end
            if (illegal) begin
                if (ill_q.size() == 0) begin
                    $display("illegal pulse without an illegal opcode outstanding");
                    errors++;
                end else begin
                    idx = ill_q.pop_front();
                    row_errs = 0;
                    check_value(idx, "illegal latency", cyc - issue_cyc[idx], 1);
                    report_row(idx, "dropped");
                end
            end
            if (in_valid) begin
                issue_cyc[cur_row] = cyc;
                if (t_ill[cur_row]) begin
                    ill_q.push_back(cur_row);
                end else begin
                    done_q.push_back(cur_row);
                end
            end
        end
    end

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        in_op    = '0;
        in_rd    = '0;
        in_rs1   = '0;
        in_rs2   = '0;
        in_imm   = '0;
        load_vectors();
        timeout_limit = RST_CYC + num_rows + LATENCY + 20;
        repeat (RST_CYC) @(posedge clk);
        rst <= 1'b0;
        // back to back, one row per cycle
        for (int i = 0; i < num_rows; i++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            in_op    <= t_op[i];
            in_rd    <= t_rd[i];
            in_rs1   <= t_rs1[i];
            in_rs2   <= t_rs2[i];
            in_imm   <= t_imm[i];
            cur_row  <= i;
        end
        @(posedge clk);
        in_valid <= 1'b0;
        while (rows_finished < num_rows) begin
            @(posedge clk);
        end
        // catch any stray done or illegal
        repeat (4) @(posedge clk);
        $display("%0d of %0d rows finished, %0d errors", rows_finished, num_rows, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- hw/alu_unit_top.sv
`timescale 1ns/1ns

module alu_unit_top #(
    parameter int WIDTH = alu_pkg::DEFAULT_WIDTH,
    parameter int REGS  = alu_pkg::DEFAULT_REGS
) (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        in_valid,
    input  logic [alu_pkg::OP_BITS-1:0] in_op,
    input  logic [$clog2(REGS)-1:0]     in_rd,
    input  logic [$clog2(REGS)-1:0]     in_rs1,
    input  logic [$clog2(REGS)-1:0]     in_rs2,
    input  logic [WIDTH-1:0]            in_imm,

    output logic                        done,
    output logic [$clog2(REGS)-1:0]     done_rd,
    output logic [WIDTH-1:0]            done_result,
    output logic                        done_zero,
    output logic                        done_overflow,
    output logic                        illegal
);

    localparam int IDX_W = $clog2(REGS);

    // decode to execute
    logic                        dec_valid;
    logic [alu_pkg::OP_BITS-1:0] dec_op;
    logic [IDX_W-1:0]            dec_rd;
    logic [IDX_W-1:0]            dec_rs1;
    logic [IDX_W-1:0]            dec_rs2;
    logic [WIDTH-1:0]            dec_imm;

    // execute to writeback
    logic                        ex_valid;
    logic [IDX_W-1:0]            ex_rd;
    logic [WIDTH-1:0]            ex_result;
    logic                        ex_overflow;

    // register file reads back into execute
    logic [WIDTH-1:0]            rf_rs1_data;
    logic [WIDTH-1:0]            rf_rs2_data;

    instr_decode #(
        .WIDTH (WIDTH),
        .REGS  (REGS)
    ) u_decode (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_rd     (in_rd),
        .in_rs1    (in_rs1),
        .in_rs2    (in_rs2),
        .in_imm    (in_imm),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .dec_rd    (dec_rd),
        .dec_rs1   (dec_rs1),
        .dec_rs2   (dec_rs2),
        .dec_imm   (dec_imm),
        .illegal   (illegal)
    );

    alu_execute #(
        .WIDTH (WIDTH),
        .REGS  (REGS)
    ) u_execute (
        .clk         (clk),
        .rst         (rst),
        .dec_valid   (dec_valid),
        .dec_op      (dec_op),
        .dec_rd      (dec_rd),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .dec_imm     (dec_imm),
        .rf_rs1_data (rf_rs1_data),
        .rf_rs2_data (rf_rs2_data),
        .ex_valid    (ex_valid),
        .ex_rd       (ex_rd),
        .ex_result   (ex_result),
        .ex_overflow (ex_overflow)
    );

    result_writeback #(
        .WIDTH (WIDTH),
        .REGS  (REGS)
    ) u_writeback (
        .clk           (clk),
        .rst           (rst),
        .ex_valid      (ex_valid),
        .ex_rd         (ex_rd),
        .ex_result     (ex_result),
        .ex_overflow   (ex_overflow),
        .dec_rs1       (dec_rs1),
        .dec_rs2       (dec_rs2),
        .rf_rs1_data   (rf_rs1_data),
        .rf_rs2_data   (rf_rs2_data),
        .done          (done),
        .done_rd       (done_rd),
        .done_result   (done_result),
        .done_zero     (done_zero),
        .done_overflow (done_overflow)
    );

endmodule

//--- hw/result_writeback.sv
`timescale 1ns/1ns

module result_writeback #(
    parameter int WIDTH = alu_pkg::DEFAULT_WIDTH,
    parameter int REGS  = alu_pkg::DEFAULT_REGS
) (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    ex_valid,
    input  logic [$clog2(REGS)-1:0] ex_rd,
    input  logic [WIDTH-1:0]        ex_result,
    input  logic                    ex_overflow,

    input  logic [$clog2(REGS)-1:0] dec_rs1,
    input  logic [$clog2(REGS)-1:0] dec_rs2,
    output logic [WIDTH-1:0]        rf_rs1_data,
    output logic [WIDTH-1:0]        rf_rs2_data,

    output logic                    done,
    output logic [$clog2(REGS)-1:0] done_rd,
    output logic [WIDTH-1:0]        done_result,
    output logic                    done_zero,
    output logic                    done_overflow
);

    logic [WIDTH-1:0] rf [REGS];

    // read ports for the instruction sitting in execute
    assign rf_rs1_data = rf[dec_rs1];
    assign rf_rs2_data = rf[dec_rs2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < REGS; i++) begin
                rf[i] <= '0;
            end
        end else if (ex_valid) begin
            rf[ex_rd] <= ex_result;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= ex_valid;
        end
    end

    // completion report, held between instructions
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done_rd       <= '0;
            done_result   <= '0;
            done_zero     <= 1'b0;
            done_overflow <= 1'b0;
        end else if (ex_valid) begin
            done_rd       <= ex_rd;
            done_result   <= ex_result;
            done_zero     <= (ex_result == '0);
            done_overflow <= ex_overflow;
        end
    end

    a_done_after_ex: assert property (
        @(posedge clk) disable iff (rst)
        done |-> $past(ex_valid)
    ) else $error("done without ex_valid the cycle before");

endmodule

//--- hw/alu_execute.sv
`timescale 1ns/1ns

module alu_execute #(
    parameter int WIDTH = alu_pkg::DEFAULT_WIDTH,
    parameter int REGS  = alu_pkg::DEFAULT_REGS
) (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       dec_valid,
    input  logic [alu_pkg::OP_BITS-1:0] dec_op,
    input  logic [$clog2(REGS)-1:0]    dec_rd,
    input  logic [$clog2(REGS)-1:0]    dec_rs1,
    input  logic [$clog2(REGS)-1:0]    dec_rs2,
    input  logic [WIDTH-1:0]           dec_imm,

    input  logic [WIDTH-1:0]           rf_rs1_data,
    input  logic [WIDTH-1:0]           rf_rs2_data,

    output logic                       ex_valid,
    output logic [$clog2(REGS)-1:0]    ex_rd,
    output logic [WIDTH-1:0]           ex_result,
    output logic                       ex_overflow
);

    logic [WIDTH-1:0] opnd_a;
    logic [WIDTH-1:0] opnd_b;
    logic [WIDTH-1:0] sum;
    logic [WIDTH-1:0] diff;
    logic             add_ovf;
    logic             sub_ovf;
    logic [WIDTH-1:0] alu_out;
    logic             alu_ovf;

    // the previous instruction has not reached the register file yet,
    // so take its result straight from the output register
    assign opnd_a = (ex_valid && ex_rd == dec_rs1) ? ex_result : rf_rs1_data;
    assign opnd_b = (ex_valid && ex_rd == dec_rs2) ? ex_result : rf_rs2_data;

    assign sum  = opnd_a + opnd_b;
    assign diff = opnd_a - opnd_b;

    // same-sign operands, result sign flipped
    assign add_ovf = (opnd_a[WIDTH-1] == opnd_b[WIDTH-1]) &&
                     (sum[WIDTH-1] != opnd_a[WIDTH-1]);
    // sub sees -b, so operand signs must differ
    assign sub_ovf = (opnd_a[WIDTH-1] != opnd_b[WIDTH-1]) &&
                     (diff[WIDTH-1] != opnd_a[WIDTH-1]);

    always_comb begin
        alu_out = '0;
        alu_ovf = 1'b0;
        case (dec_op)
            alu_pkg::OP_ADD: begin
                alu_out = sum;
                alu_ovf = add_ovf;
            end
            alu_pkg::OP_SUB: begin
                alu_out = diff;
                alu_ovf = sub_ovf;
            end
            alu_pkg::OP_AND: begin
                alu_out = opnd_a & opnd_b;
            end
            alu_pkg::OP_OR: begin
                alu_out = opnd_a | opnd_b;
            end
            alu_pkg::OP_XOR: begin
                alu_out = opnd_a ^ opnd_b;
            end
            alu_pkg::OP_NOT: begin
                alu_out = ~opnd_a;
            end
            alu_pkg::OP_EQ: begin
                alu_out = {{(WIDTH-1){1'b0}}, opnd_a == opnd_b};
            end
            alu_pkg::OP_LT: begin
                alu_out = {{(WIDTH-1){1'b0}}, $signed(opnd_a) < $signed(opnd_b)};
            end
            alu_pkg::OP_GT: begin
                alu_out = {{(WIDTH-1){1'b0}}, $signed(opnd_a) > $signed(opnd_b)};
            end
            alu_pkg::OP_LDI: begin
                alu_out = dec_imm;
            end
            default: begin
                alu_out = '0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_valid    <= 1'b0;
            ex_overflow <= 1'b0;
        end else begin
            ex_valid    <= dec_valid;
            ex_overflow <= dec_valid & alu_ovf;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_rd     <= '0;
            ex_result <= '0;
        end else if (dec_valid) begin
            ex_rd     <= dec_rd;
            ex_result <= alu_out;
        end
    end

    // overflow flag only ever comes from an add or sub one cycle back
    a_ovf_arith_only: assert property (
        @(posedge clk) disable iff (rst)
        ex_overflow |-> $past(dec_valid &&
            (dec_op == alu_pkg::OP_ADD || dec_op == alu_pkg::OP_SUB))
    ) else $error("ex_overflow set by a non-arithmetic op");

endmodule

//--- hw/instr_decode.sv
`timescale 1ns/1ns

module instr_decode #(
    parameter int WIDTH = alu_pkg::DEFAULT_WIDTH,
    parameter int REGS  = alu_pkg::DEFAULT_REGS
) (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       in_valid,
    input  logic [alu_pkg::OP_BITS-1:0] in_op,
    input  logic [$clog2(REGS)-1:0]    in_rd,
    input  logic [$clog2(REGS)-1:0]    in_rs1,
    input  logic [$clog2(REGS)-1:0]    in_rs2,
    input  logic [WIDTH-1:0]           in_imm,

    output logic                       dec_valid,
    output logic [alu_pkg::OP_BITS-1:0] dec_op,
    output logic [$clog2(REGS)-1:0]    dec_rd,
    output logic [$clog2(REGS)-1:0]    dec_rs1,
    output logic [$clog2(REGS)-1:0]    dec_rs2,
    output logic [WIDTH-1:0]           dec_imm,

    output logic                       illegal
);

    logic op_legal;

    // codes above ldi have no meaning here
    assign op_legal = (in_op <= alu_pkg::OP_LDI);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_valid <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            dec_valid <= in_valid & op_legal;
            illegal   <= in_valid & ~op_legal;
        end
    end

    // fields only follow a strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_op  <= '0;
            dec_rd  <= '0;
            dec_rs1 <= '0;
            dec_rs2 <= '0;
            dec_imm <= '0;
        end else if (in_valid) begin
            dec_op  <= in_op;
            dec_rd  <= in_rd;
            dec_rs1 <= in_rs1;
            dec_rs2 <= in_rs2;
            dec_imm <= in_imm;
        end
    end

    // a dropped instruction must never reach execute
    a_illegal_not_issued: assert property (
        @(posedge clk) disable iff (rst)
        illegal |-> !dec_valid
    ) else $error("illegal and dec_valid high together");

endmodule

//--- hw/alu_pkg.sv
package alu_pkg;

    // opcode field width
    localparam int OP_BITS = 4;

    // default data path and register file size
    localparam int DEFAULT_WIDTH = 32;
    localparam int DEFAULT_REGS  = 8;

    // arithmetic
    localparam logic [OP_BITS-1:0] OP_ADD = 4'd0;
    localparam logic [OP_BITS-1:0] OP_SUB = 4'd1;

    // bitwise logic
    localparam logic [OP_BITS-1:0] OP_AND = 4'd2;
    localparam logic [OP_BITS-1:0] OP_OR  = 4'd3;
    localparam logic [OP_BITS-1:0] OP_XOR = 4'd4;
    localparam logic [OP_BITS-1:0] OP_NOT = 4'd5;

    // compares, result is 1 or 0
    localparam logic [OP_BITS-1:0] OP_EQ  = 4'd6;
    localparam logic [OP_BITS-1:0] OP_LT  = 4'd7;
    localparam logic [OP_BITS-1:0] OP_GT  = 4'd8;

    // load immediate into rd
    // highest legal code, 10..15 are rejected in decode
    localparam logic [OP_BITS-1:0] OP_LDI = 4'd9;

endpackage
